/* hdl/noc_flit_pkg.sv */
package noc_flit_pkg;

	// flit layout, msb first
	// [7] head flag, [6:4] destination, [3:0] payload
	localparam int FLIT_W = 8;
	localparam int DEST_W = 3;

	localparam int HEAD_BIT = FLIT_W - 1;
	localparam int DEST_HI = HEAD_BIT - 1;
	localparam int DEST_LO = DEST_HI - DEST_W + 1;

	// one flit as carried on every channel
	typedef logic [FLIT_W-1:0] flit_t;

	// destination node id taken from a head flit
	typedef logic [DEST_W-1:0] dest_t;

	// index of an input or output port, two ports per side
	typedef logic port_t;

endpackage

/* hdl/noc_ctrl_pkg.sv */
package noc_ctrl_pkg;

	// receive side packet buffer
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_STORE,
		RX_CH_WAIT,
		RX_SEND
	} rx_state_t;

	// output sender, one flit per load/send/wait round
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_LOAD,
		TX_SEND,
		TX_WAIT_ACK,
		TX_RELEASE
	} tx_state_t;

endpackage

/* hdl/flit_if.sv */
interface flit_if;

	import noc_flit_pkg::*;

	// single cycle strobe per decoded flit
	logic valid;
	flit_t flit;
	logic head;
	// output choice, only looked at with head set
	port_t out_chnl;

	modport source (
		output valid,
		output flit,
		output head,
		output out_chnl
	);

	modport sink (
		input valid,
		input flit,
		input head,
		input out_chnl
	);

endinterface

/* hdl/rx_decode.sv */
module rx_decode #(
	parameter noc_flit_pkg::dest_t LOCAL_ID = '0
) (
	input logic clk,
	input logic reset,
	input logic ch_req,
	input noc_flit_pkg::flit_t ch_flit,
	flit_if.source dec
);

	import noc_flit_pkg::*;

	logic req_q;
	logic req_edge;
	logic pend;
	logic valid_q;
	flit_t flit_q;
	dest_t dest;

	// sender toggles ch_req once per flit
	assign req_edge = ch_req ^ req_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			req_q <= 1'b0;
			pend <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			req_q <= ch_req;
			pend <= req_edge;
			// classification takes one more cycle
			valid_q <= pend;
		end
	end

	// flit held stable by the sender until acked
	always_ff @(posedge clk) begin
		if (req_edge) begin
			flit_q <= ch_flit;
		end
	end

	assign dest = flit_q[DEST_HI:DEST_LO];

	assign dec.valid = valid_q;
	assign dec.flit = flit_q;
	assign dec.head = flit_q[HEAD_BIT];
	// local delivery on output 0, everything else forwarded
	assign dec.out_chnl = (dest == LOCAL_ID) ? 1'b0 : 1'b1;

	// next toggle cannot come before the ack, so strobes stay single
	a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		valid_q |=> !valid_q);

endmodule

/* hdl/rx_buffer.sv */
module rx_buffer #(
	parameter int BUFF_BITS = 3
) (
	input logic clk,
	input logic reset,
	flit_if.sink dec,
	output logic ch_ack,
	output logic sw_req,
	output noc_flit_pkg::port_t sw_chnl,
	input logic sw_gnt,
	input logic [BUFF_BITS-1:0] buf_addr,
	output noc_flit_pkg::flit_t buf_data
);

	import noc_flit_pkg::*;
	import noc_ctrl_pkg::*;

	localparam int FLIT_COUNT = 2 ** BUFF_BITS;
	localparam logic [BUFF_BITS-1:0] LAST = '1;

	rx_state_t state;
	logic [BUFF_BITS-1:0] count;
	flit_t mem [FLIT_COUNT];

	// read port for the granted sender
	assign buf_data = mem[buf_addr];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= RX_IDLE;
			count <= '0;
			ch_ack <= 1'b0;
			sw_req <= 1'b0;
			sw_chnl <= '0;
			for (int i = 0; i < FLIT_COUNT; i++) begin
				mem[i] <= '0;
			end
		end else begin
			case (state)
				RX_IDLE, RX_STORE: begin
					if (dec.valid) begin
						mem[count] <= dec.flit;
						// route comes from the head flit only
						if (dec.head) begin
							sw_chnl <= dec.out_chnl;
						end
						if (count == LAST) begin
							// last flit, its ack waits for the send
							sw_req <= 1'b1;
							state <= RX_CH_WAIT;
						end else begin
							ch_ack <= ~ch_ack;
							count <= count + 1'b1;
							state <= RX_STORE;
						end
					end
				end
				RX_CH_WAIT: begin
					if (sw_gnt) begin
						state <= RX_SEND;
					end
				end
				RX_SEND: begin
					sw_req <= 1'b0;
					// grant falls once the sender is done
					if (!sw_gnt) begin
						ch_ack <= ~ch_ack;
						count <= '0;
						state <= RX_IDLE;
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// packets are fixed length, so a head can only start one
	a_head_first: assert property (@(posedge clk) disable iff (reset)
		dec.valid && dec.head |-> count == '0);

	// request is held until the crossbar answers
	a_req_hold: assert property (@(posedge clk) disable iff (reset)
		sw_req && !sw_gnt |=> sw_req);

endmodule

/* hdl/switch_crossbar.sv */
module switch_crossbar #(
	parameter int BUFF_BITS = 3
) (
	input logic clk,
	input logic reset,
	input logic [1:0] sw_req,
	input noc_flit_pkg::port_t sw_chnl [2],
	output logic [1:0] sw_gnt,
	output logic [BUFF_BITS-1:0] rx_addr [2],
	input noc_flit_pkg::flit_t rx_data [2],
	output logic [1:0] start,
	input logic [1:0] done,
	input logic [BUFF_BITS-1:0] tx_addr [2],
	output noc_flit_pkg::flit_t tx_data [2]
);

	import noc_flit_pkg::*;

	// per output state
	logic [1:0] busy;
	port_t owner [2];
	port_t last [2];
	logic [1:0] want [2];
	port_t pick [2];

	// an input holds a grant while either output is busy for it
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			sw_gnt[i] = (busy[0] && owner[0] == port_t'(i)) ||
				(busy[1] && owner[1] == port_t'(i));
		end
	end

	always_comb begin
		for (int o = 0; o < 2; o++) begin
			for (int i = 0; i < 2; i++) begin
				want[o][i] = sw_req[i] && !sw_gnt[i] && (sw_chnl[i] == port_t'(o));
			end
			// round robin when both inputs want the same output
			if (&want[o]) begin
				pick[o] = ~last[o];
			end else begin
				pick[o] = want[o][1];
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= '0;
			start <= '0;
			for (int o = 0; o < 2; o++) begin
				owner[o] <= '0;
				last[o] <= 1'b1;
			end
		end else begin
			for (int o = 0; o < 2; o++) begin
				start[o] <= 1'b0;
				if (busy[o]) begin
					if (done[o]) begin
						busy[o] <= 1'b0;
					end
				end else if (|want[o]) begin
					busy[o] <= 1'b1;
					owner[o] <= pick[o];
					last[o] <= pick[o];
					start[o] <= 1'b1;
				end
			end
		end
	end

	// read path follows the owner of each output
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			rx_addr[i] = (busy[1] && owner[1] == port_t'(i)) ? tx_addr[1] : tx_addr[0];
		end
		for (int o = 0; o < 2; o++) begin
			tx_data[o] = rx_data[owner[o]];
		end
	end

	a_one_output: assert property (@(posedge clk) disable iff (reset)
		!(busy[0] && busy[1] && owner[0] == owner[1]));

endmodule

/* hdl/tx_result.sv */
module tx_result #(
	parameter int BUFF_BITS = 3
) (
	input logic clk,
	input logic reset,
	input logic start,
	output logic done,
	output logic [BUFF_BITS-1:0] buf_addr,
	input noc_flit_pkg::flit_t buf_data,
	output logic out_req,
	output noc_flit_pkg::flit_t out_flit,
	input logic out_ack
);

	import noc_ctrl_pkg::*;

	localparam logic [BUFF_BITS-1:0] LAST = '1;

	tx_state_t state;

	// one cycle strobe frees the crossbar grant
	assign done = (state == TX_RELEASE);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= TX_IDLE;
			buf_addr <= '0;
			out_req <= 1'b0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (start) begin
						buf_addr <= '0;
						state <= TX_LOAD;
					end
				end
				TX_LOAD: begin
					state <= TX_SEND;
				end
				TX_SEND: begin
					out_req <= ~out_req;
					state <= TX_WAIT_ACK;
				end
				TX_WAIT_ACK: begin
					// downstream may take as long as it likes
					if (out_ack == out_req) begin
						if (buf_addr == LAST) begin
							state <= TX_RELEASE;
						end else begin
							buf_addr <= buf_addr + 1'b1;
							state <= TX_LOAD;
						end
					end
				end
				TX_RELEASE: begin
					state <= TX_IDLE;
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

	// flit stays on the output until the next load
	always_ff @(posedge clk) begin
		if (state == TX_LOAD) begin
			out_flit <= buf_data;
		end
	end

endmodule

/* hdl/noc_router.sv */
module noc_router #(
	parameter int BUFF_BITS = 3,
	parameter noc_flit_pkg::dest_t LOCAL_ID = '0
) (
	input logic clk,
	input logic reset,
	input logic in0_req,
	input noc_flit_pkg::flit_t in0_flit,
	output logic in0_ack,
	input logic in1_req,
	input noc_flit_pkg::flit_t in1_flit,
	output logic in1_ack,
	output logic out0_req,
	output noc_flit_pkg::flit_t out0_flit,
	input logic out0_ack,
	output logic out1_req,
	output noc_flit_pkg::flit_t out1_flit,
	input logic out1_ack
);

	import noc_flit_pkg::*;

	logic [1:0] in_req;
	logic [1:0] in_ack;
	logic [1:0] out_req;
	logic [1:0] out_ack;
	flit_t in_flit [2];
	flit_t out_flit [2];

	logic [1:0] sw_req;
	logic [1:0] sw_gnt;
	logic [1:0] start;
	logic [1:0] done;
	port_t sw_chnl [2];
	logic [BUFF_BITS-1:0] rx_addr [2];
	logic [BUFF_BITS-1:0] tx_addr [2];
	flit_t rx_data [2];
	flit_t tx_data [2];

	// gather the external channels into port arrays
	assign in_req = {in1_req, in0_req};
	assign in_flit[0] = in0_flit;
	assign in_flit[1] = in1_flit;
	assign in0_ack = in_ack[0];
	assign in1_ack = in_ack[1];
	assign out_ack = {out1_ack, out0_ack};
	assign out0_req = out_req[0];
	assign out1_req = out_req[1];
	assign out0_flit = out_flit[0];
	assign out1_flit = out_flit[1];

	for (genvar p = 0; p < 2; p++) begin : g_port
		flit_if dec_if ();

		rx_decode #(.LOCAL_ID(LOCAL_ID)) u_decode (
			.clk(clk),
			.reset(reset),
			.ch_req(in_req[p]),
			.ch_flit(in_flit[p]),
			.dec(dec_if.source)
		);

		rx_buffer #(.BUFF_BITS(BUFF_BITS)) u_buffer (
			.clk(clk),
			.reset(reset),
			.dec(dec_if.sink),
			.ch_ack(in_ack[p]),
			.sw_req(sw_req[p]),
			.sw_chnl(sw_chnl[p]),
			.sw_gnt(sw_gnt[p]),
			.buf_addr(rx_addr[p]),
			.buf_data(rx_data[p])
		);

		// p indexes an output here
		tx_result #(.BUFF_BITS(BUFF_BITS)) u_result (
			.clk(clk),
			.reset(reset),
			.start(start[p]),
			.done(done[p]),
			.buf_addr(tx_addr[p]),
			.buf_data(tx_data[p]),
			.out_req(out_req[p]),
			.out_flit(out_flit[p]),
			.out_ack(out_ack[p])
		);
	end

	switch_crossbar #(.BUFF_BITS(BUFF_BITS)) u_crossbar (
		.clk(clk),
		.reset(reset),
		.sw_req(sw_req),
		.sw_chnl(sw_chnl),
		.sw_gnt(sw_gnt),
		.rx_addr(rx_addr),
		.rx_data(rx_data),
		.start(start),
		.done(done),
		.tx_addr(tx_addr),
		.tx_data(tx_data)
	);

endmodule

/* bench/tb_noc_router.sv */
module tb_noc_router;

	import noc_flit_pkg::*;

	localparam int BUFF_BITS = 3;
	localparam dest_t LOCAL_ID = 3'd0;
	localparam int PKT_LEN = 2 ** BUFF_BITS;
	localparam int NUM_RANDOM = 40;
	localparam int ACK_LIMIT = 2000;
	localparam int DRAIN_LIMIT = 5000;

	logic clk;
	logic reset;
	logic [1:0] in_req;
	flit_t in_flit [2];
	wire [1:0] in_ack;
	wire [1:0] out_req;
	flit_t out_flit [2];
	logic [1:0] out_ack;

	int seed;
	int errors;
	// expected flits, indexed by output * 2 + input
	flit_t exp_q [4][$];
	logic [2:0] seq [2];
	int pkts_sent [2];
	int acked_flits [2];
	int pos [2];
	int cur_src [2];
	dest_t rand_dest [2][NUM_RANDOM];
	int delay_tab [2][256];

	noc_router #(.BUFF_BITS(BUFF_BITS), .LOCAL_ID(LOCAL_ID)) dut (
		.clk(clk),
		.reset(reset),
		.in0_req(in_req[0]),
		.in0_flit(in_flit[0]),
		.in0_ack(in_ack[0]),
		.in1_req(in_req[1]),
		.in1_flit(in_flit[1]),
		.in1_ack(in_ack[1]),
		.out0_req(out_req[0]),
		.out0_flit(out_flit[0]),
		.out0_ack(out_ack[0]),
		.out1_req(out_req[1]),
		.out1_flit(out_flit[1]),
		.out1_ack(out_ack[1])
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic int pending();
		int n;
		n = 0;
		for (int q = 0; q < 4; q++) begin
			n += exp_q[q].size();
		end
		return n;
	endfunction

	// compare one output flit against the model
	task automatic check_flit(input int o, input flit_t f);
		int src;
		flit_t exp;
		src = int'(f[3]);
		if (pos[o] == 0) begin
			cur_src[o] = src;
		end else if (src != cur_src[o]) begin
			$display("output %0d mixed flits of inputs %0d and %0d in one packet",
				o, cur_src[o], src);
			errors++;
		end
		if (exp_q[o * 2 + src].size() == 0) begin
			$display("output %0d sent flit %h while no flit was expected", o, f);
			errors++;
		end else begin
			exp = exp_q[o * 2 + src].pop_front();
			if (f !== exp) begin
				$display("MISMATCH at %0t: out%0d_flit expected %h, got %h", $time, o, exp, f);
				errors++;
			end
		end
		pos[o] = (pos[o] + 1) % PKT_LEN;
	endtask

	// downstream side of one output, acks after a random delay
	task automatic respond(input int o);
		flit_t f;
		int idx;
		idx = 0;
		forever begin
			@(negedge clk);
			if (out_req[o] != out_ack[o]) begin
				f = out_flit[o];
				check_flit(o, f);
				repeat (delay_tab[o][idx % 256]) @(negedge clk);
				idx++;
				out_ack[o] = ~out_ack[o];
				acked_flits[int'(f[3])]++;
			end
		end
	endtask

	task automatic send_packet(input int p, input dest_t dest);
		flit_t pkt [PKT_LEN];
		int out;
		int target;
		int cycles;
		out = (dest == LOCAL_ID) ? 0 : 1;
		target = (pkts_sent[p] + 1) * PKT_LEN;
		for (int n = 0; n < PKT_LEN; n++) begin
			pkt[n] = {(n == 0), (n == 0) ? dest : 3'd0, p[0], seq[p]};
			seq[p] = seq[p] + 3'd1;
			exp_q[out * 2 + p].push_back(pkt[n]);
		end
		for (int n = 0; n < PKT_LEN; n++) begin
			@(negedge clk);
			in_flit[p] = pkt[n];
			in_req[p] = ~in_req[p];
			cycles = 0;
			while (in_ack[p] != in_req[p] && cycles < ACK_LIMIT) begin
				@(negedge clk);
				cycles++;
			end
			if (in_ack[p] != in_req[p]) begin
				$display("timeout: input %0d never acknowledged flit %0d", p, n);
				errors++;
			end else if (n == PKT_LEN - 1 && acked_flits[p] < target) begin
				$display("input %0d acked its last flit before the packet left", p);
				errors++;
			end else if (n < PKT_LEN - 1 && acked_flits[p] != target - PKT_LEN) begin
				$display("input %0d acked flit %0d after output already started", p, n);
				errors++;
			end
		end
		pkts_sent[p]++;
	endtask

	task automatic random_stream(input int p);
		for (int k = 0; k < NUM_RANDOM; k++) begin
			send_packet(p, rand_dest[p][k]);
		end
	endtask

	task automatic drain();
		int cycles;
		cycles = 0;
		while ((pending() != 0 || out_req != out_ack) && cycles < DRAIN_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (pending() != 0 || out_req != out_ack) begin
			$display("timeout: %0d expected flits never came out", pending());
			errors++;
		end
	endtask

	initial begin
		reset = 1'b1;
		in_req = '0;
		in_flit[0] = '0;
		in_flit[1] = '0;
		out_ack = '0;
		seed = 51;
		errors = 0;
		for (int p = 0; p < 2; p++) begin
			seq[p] = '0;
			pkts_sent[p] = 0;
			acked_flits[p] = 0;
			pos[p] = 0;
			cur_src[p] = 0;
			for (int k = 0; k < NUM_RANDOM; k++) begin
				rand_dest[p][k] = dest_t'($unsigned($random(seed)));
			end
			for (int k = 0; k < 256; k++) begin
				delay_tab[p][k] = $unsigned($random(seed)) % 7;
			end
		end
		repeat (8) @(negedge clk);
		reset = 1'b0;

		// idle outputs and acks after reset
		repeat (4) begin
			@(negedge clk);
			for (int p = 0; p < 2; p++) begin
				if (out_req[p] !== 1'b0) begin
					$display("MISMATCH at %0t: out%0d_req expected 0, got %b", $time, p, out_req[p]);
					errors++;
				end
				if (in_ack[p] !== 1'b0) begin
					$display("MISMATCH at %0t: in%0d_ack expected 0, got %b", $time, p, in_ack[p]);
					errors++;
				end
			end
		end

		fork
			respond(0);
			respond(1);
		join_none

		// routing, one packet to each output
		send_packet(0, LOCAL_ID);
		drain();
		send_packet(1, 3'd5);
		drain();
		// contention on each output
		fork
			send_packet(0, LOCAL_ID);
			send_packet(1, LOCAL_ID);
		join
		drain();
		fork
			send_packet(0, 3'd2);
			send_packet(1, 3'd7);
		join
		drain();
		// parallel, different outputs
		fork
			send_packet(0, LOCAL_ID);
			send_packet(1, 3'd6);
		join
		drain();
		fork
			random_stream(0);
			random_stream(1);
		join
		drain();

		$display("errors: %0d, expected flits left: %0d", errors, pending());
		if (errors == 0 && pending() == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* list.f */
hdl/noc_flit_pkg.sv
hdl/noc_ctrl_pkg.sv
hdl/flit_if.sv
hdl/rx_decode.sv
hdl/rx_buffer.sv
hdl/switch_crossbar.sv
hdl/tx_result.sv
hdl/noc_router.sv
bench/tb_noc_router.sv

/* run.sh */
#!/bin/sh
# build the router testbench with verilator, run it, then look for the pass line
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_noc_router \
	-f list.f -o tb_noc_router > build.log 2>&1 \
	&& ./obj_dir/tb_noc_router > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Verification passed" sim.log && exit 0 || exit 1
